// ==== build.f ====
common/kbd_pkg.sv
common/key_event_if.sv
ps2/ps2_rx.sv
verilog/key_decoder.sv
verilog/ascii_map.sv
verilog/kbd_top.sv
test/tb_kbd_top.sv

// ==== common/kbd_pkg.sv ====
package kbd_pkg;

    // scan code and ascii character width
    localparam int CODE_W = 8;

    // set 2 codes the decoder acts on
    typedef enum logic [CODE_W-1:0] {
        SC_LALT   = 8'h11,
        SC_LSHIFT = 8'h12,
        SC_LCTRL  = 8'h14,
        SC_CAPS   = 8'h58,
        SC_RSHIFT = 8'h59,
        SC_EXTEND = 8'hE0,
        SC_BREAK  = 8'hF0
    } scan_code_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BREAK,     // F0 seen
        ST_EXT,       // E0 seen
        ST_EXT_BREAK  // E0 F0 seen
    } dec_state_t;

    // start bit is sent first and held in bit 0
    typedef struct packed {
        logic              stop;
        logic              parity;
        logic [CODE_W-1:0] data;
        logic              start;
    } ps2_frame_t;

endpackage

// ==== common/key_event_if.sv ====
`timescale 1ns/1ps

interface key_event_if;
    import kbd_pkg::*;

    logic              valid;            // one-cycle press strobe
    logic [CODE_W-1:0] code;
    logic              shift;
    logic              caps;
    logic              alt_ctrl_active;

    modport src (output valid, output code, output shift, output caps, output alt_ctrl_active);
    modport dst (input valid, input code, input shift, input caps, input alt_ctrl_active);

endinterface

// ==== ps2/ps2_rx.sv ====
`timescale 1ns/1ps

module ps2_rx (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_ps2_clk,
    input  logic                       i_ps2_data,
    output logic                       o_code_valid,
    output logic [kbd_pkg::CODE_W-1:0] o_code
);
    import kbd_pkg::*;

    localparam int FRAME_W = $bits(ps2_frame_t);

    logic [2:0] clk_sync;
    logic [1:0] data_sync;
    logic       fall_q;
    logic [3:0] bit_cnt;
    logic       last_bit;
    logic       frame_ok;
    ps2_frame_t shift_q;
    ps2_frame_t frame;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clk_sync  <= 3'b111;  // lines idle high
            data_sync <= 2'b11;
            fall_q    <= 1'b0;
        end else begin
            clk_sync  <= {clk_sync[1:0], i_ps2_clk};
            data_sync <= {data_sync[0], i_ps2_data};
            fall_q    <= clk_sync[2] & ~clk_sync[1];
        end
    end

    // data is held for a full half period, so the sync delay is harmless
    assign frame    = ps2_frame_t'({data_sync[1], shift_q[FRAME_W-1:1]});
    assign last_bit = (bit_cnt == 4'(FRAME_W - 1));
    assign frame_ok = !frame.start && frame.stop && (^{frame.data, frame.parity});

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt      <= '0;
            o_code_valid <= 1'b0;
        end else begin
            o_code_valid <= 1'b0;
            if (fall_q) begin
                if (last_bit) begin
                    bit_cnt      <= '0;
                    o_code_valid <= frame_ok;  // bad frames vanish here
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fall_q) begin
            shift_q <= frame;
        end
        if (fall_q && last_bit && frame_ok) begin
            o_code <= frame.data;
        end
    end

    a_single_strobe : assert property (
        @(posedge clk) disable iff (rst) o_code_valid |=> !o_code_valid
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_kbd_top -o tb_kbd_top
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/tb_kbd_top > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
exit 0

// ==== test/tb_kbd_top.sv ====
`timescale 1ns/1ps

module tb_kbd_top;
    import kbd_pkg::*;

    localparam int HALF_BIT = 20;   // clk cycles per PS/2 half period
    localparam int LIMIT    = 200;  // cycles allowed for any wait
    localparam logic [8*26-1:0] LETTER_CODE = {8'h1c, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2b, 8'h34,
        8'h33, 8'h43, 8'h3b, 8'h42, 8'h4b, 8'h3a, 8'h31, 8'h44, 8'h4d, 8'h15, 8'h2d, 8'h1b,
        8'h2c, 8'h3c, 8'h2a, 8'h1d, 8'h22, 8'h35, 8'h1a};  // a to z
    // digits 0 to 9, then the eleven punctuation keys
    localparam logic [8*21-1:0] SYM_CODE = {8'h45, 8'h16, 8'h1e, 8'h26, 8'h25, 8'h2e, 8'h36,
        8'h3d, 8'h3e, 8'h46, 8'h0e, 8'h4e, 8'h55, 8'h54, 8'h5b, 8'h5d, 8'h4c, 8'h52, 8'h41,
        8'h49, 8'h4a};
    localparam logic [8*21-1:0] SYM_LO = {"0123456789", 8'h60, "-=[]\\;',./"};
    localparam logic [8*21-1:0] SYM_HI = ")!@#$%^&*(~_+{}|:\"<>?";

    logic        clk;
    logic        rst;
    logic        i_ps2_clk;
    logic        i_ps2_data;
    logic        o_ascii_valid;
    logic [7:0]  o_ascii;
    logic        o_ctrl;
    logic        o_alt;
    logic        o_shift;
    logic        o_caps;
    logic [7:0]  o_release_cnt;
    logic [7:0]  ascii_q[$];  // characters seen on the strobe
    logic [31:0] lcg_state = 32'hea0d;
    logic        exp_ctrl  = 1'b0;
    logic        exp_alt   = 1'b0;
    logic        exp_shift = 1'b0;
    logic        exp_caps  = 1'b0;
    logic [7:0]  exp_rel   = 8'd0;

    kbd_top #(.RELEASE_CNT_W(8)) u_dut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (o_ascii_valid) begin
            ascii_q.push_back(o_ascii);
        end
    end

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s, got %0h, expected %0h",
                     $time, msg, actual, expected);
            abort_run();
        end
    endtask

    function automatic int pick_letter();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]) % 26;
    endfunction

    function automatic logic [7:0] letter_char(input int idx);
        return (exp_shift ^ exp_caps) ? 8'("A" + idx) : 8'("a" + idx);
    endfunction

    // corrupt selects a good frame (0), bad parity (1) or a bad stop bit (2)
    task automatic send_byte(input logic [7:0] b, input int corrupt);
        ps2_frame_t  f;
        logic [10:0] bits;
        int          i;
        f = '{stop: corrupt != 2, parity: (~^b) ^ (corrupt == 1), data: b, start: 1'b0};
        bits = f;
        for (i = 0; i < 11; i++) begin
            @(posedge clk);
            i_ps2_data <= bits[i];
            repeat (HALF_BIT) @(posedge clk);
            i_ps2_clk <= 1'b0;  // receiver samples on this edge
            repeat (HALF_BIT) @(posedge clk);
            i_ps2_clk <= 1'b1;
        end
        @(posedge clk);
        i_ps2_data <= 1'b1;
        repeat (2 * HALF_BIT) @(posedge clk);
    endtask

    task automatic check_state(input string what);
        check(32'(o_ctrl), 32'(exp_ctrl), {what, ": ctrl"});
        check(32'(o_alt), 32'(exp_alt), {what, ": alt"});
        check(32'(o_shift), 32'(exp_shift), {what, ": shift"});
        check(32'(o_caps), 32'(exp_caps), {what, ": caps"});
        check(32'(o_release_cnt), 32'(exp_rel), {what, ": release count"});
    endtask

    task automatic wait_ascii(input logic [7:0] expected, input string what);
        int waited;
        waited = 0;
        while (ascii_q.size() == 0 && waited < LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (ascii_q.size() == 0) begin
            $display("no ASCII character arrived within %0d cycles after %s", LIMIT, what);
            abort_run();
        end else begin
            check(32'(ascii_q.pop_front()), 32'(expected), what);
        end
    endtask

    task automatic expect_silence(input string what);
        int waited;
        waited = 0;
        while (ascii_q.size() == 0 && waited < LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (ascii_q.size() != 0) begin
            $display("unexpected ASCII character %02h after %s", ascii_q[0], what);
            abort_run();
        end
        check_state(what);
    endtask

    // sends a press or a break sequence and updates the expected flags
    task automatic key_event(input logic [7:0] code, input logic release_key);
        if (release_key) begin
            send_byte(SC_BREAK, 0);
            exp_rel = exp_rel + 8'd1;
        end
        send_byte(code, 0);
        case (code)
            SC_LCTRL:             exp_ctrl = !release_key;
            SC_LALT:              exp_alt = !release_key;
            SC_LSHIFT, SC_RSHIFT: exp_shift = !release_key;
            SC_CAPS:              exp_caps = exp_caps ^ !release_key;
            default:              ;
        endcase
    endtask

    task automatic type_key(input logic [7:0] code, input logic [7:0] expected,
                            input string what);
        key_event(code, 1'b0);
        wait_ascii(expected, what);
        key_event(code, 1'b1);
        expect_silence({what, " release"});
    endtask

    task automatic extended_key(input logic [7:0] code);
        send_byte(SC_EXTEND, 0);
        send_byte(code, 0);
        expect_silence("extended press");
        send_byte(SC_EXTEND, 0);
        send_byte(SC_BREAK, 0);
        send_byte(code, 0);
        exp_rel = exp_rel + 8'd1;
        expect_silence("extended release");
    endtask

    task automatic reset_values();
        check_state("after reset");
        check(32'(o_ascii_valid), 32'd0, "ascii strobe after reset");
        check(32'(o_ascii), 32'd0, "ascii after reset");
    endtask

    // four passes with plain keys, shift held, caps on, then both
    task automatic letter_case();
        int pass;
        int n;
        int idx;
        for (pass = 0; pass < 4; pass++) begin
            if (pass == 1 || pass == 3) begin
                key_event(SC_LSHIFT, 1'b0);
            end
            if (pass == 2) begin
                key_event(SC_LSHIFT, 1'b1);
                key_event(SC_CAPS, 1'b0);
                key_event(SC_CAPS, 1'b1);
            end
            expect_silence("modifier change");
            for (n = 0; n < 2; n++) begin
                idx = pick_letter();
                type_key(LETTER_CODE[8*(25-idx) +: 8], letter_char(idx), "letter");
            end
        end
        key_event(SC_LSHIFT, 1'b1);
        key_event(SC_CAPS, 1'b0);
        key_event(SC_CAPS, 1'b1);
        expect_silence("modifiers cleared");
    endtask

    task automatic digits_and_symbols();
        int s;
        int i;
        for (s = 0; s < 2; s++) begin
            if (s == 1) begin
                key_event(SC_RSHIFT, 1'b0);
                expect_silence("right shift press");
            end
            for (i = 0; i < 21; i++) begin
                type_key(SYM_CODE[8*(20-i) +: 8],
                         exp_shift ? SYM_HI[8*(20-i) +: 8] : SYM_LO[8*(20-i) +: 8], "symbol");
            end
            type_key(8'h29, 8'h20, "space");
        end
        key_event(SC_RSHIFT, 1'b1);
        expect_silence("right shift release");
    endtask

    task automatic release_counting();
        logic [7:0] start_cnt;
        start_cnt = exp_rel;
        key_event(SC_LSHIFT, 1'b0);
        expect_silence("shift press");
        key_event(SC_LSHIFT, 1'b1);
        expect_silence("shift release");
        key_event(8'h1c, 1'b1);  // release with no press before it
        expect_silence("lone letter release");
        extended_key(8'h75);
        check(32'(o_release_cnt), 32'(start_cnt + 8'd3), "three releases counted");
    endtask

    task automatic frame_errors();
        send_byte(8'h1c, 1);
        expect_silence("bad parity frame");
        send_byte(8'h1c, 2);
        expect_silence("bad stop frame");
        send_byte(SC_BREAK, 1);  // if kept, the next press would decode as a release
        expect_silence("bad parity break code");
        type_key(8'h1c, letter_char(0), "letter after bad frames");
    endtask

    task automatic ctrl_alt_extended();
        int         m;
        int         idx;
        logic [7:0] mod;
        for (m = 0; m < 2; m++) begin
            mod = m ? SC_LALT : SC_LCTRL;
            key_event(mod, 1'b0);
            expect_silence("ctrl or alt press");
            idx = pick_letter();
            type_key(LETTER_CODE[8*(25-idx) +: 8], letter_char(idx), "letter with ctrl or alt");
            key_event(mod, 1'b1);
            expect_silence("ctrl or alt release");
        end
        extended_key(SC_LCTRL);  // right ctrl leaves the flag alone
        extended_key(8'h1c);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        i_ps2_clk  = 1'b1;
        i_ps2_data = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        reset_values();
        letter_case();
        digits_and_symbols();
        release_counting();
        frame_errors();
        ctrl_alt_extended();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== verilog/ascii_map.sv ====
`timescale 1ns/1ps

module ascii_map (
    input  logic                       clk,
    input  logic                       rst,
    key_event_if.dst                   ev,
    output logic                       o_ascii_valid,
    output logic [kbd_pkg::CODE_W-1:0] o_ascii
);
    import kbd_pkg::*;

    typedef enum logic [1:0] {
        K_NONE,
        K_LETTER,  // case follows shift xor caps
        K_SYMBOL   // shifted form follows shift only
    } char_kind_t;

    typedef struct packed {
        char_kind_t        kind;
        logic [CODE_W-1:0] lo;
        logic [CODE_W-1:0] hi;
    } map_ent_t;

    map_ent_t          ent;
    logic              upper;
    logic [CODE_W-1:0] ch;

    // us layout
    always_comb begin
        case (ev.code)
            8'h1c:   ent = '{K_LETTER, "a", "A"};
            8'h32:   ent = '{K_LETTER, "b", "B"};
            8'h21:   ent = '{K_LETTER, "c", "C"};
            8'h23:   ent = '{K_LETTER, "d", "D"};
            8'h24:   ent = '{K_LETTER, "e", "E"};
            8'h2b:   ent = '{K_LETTER, "f", "F"};
            8'h34:   ent = '{K_LETTER, "g", "G"};
            8'h33:   ent = '{K_LETTER, "h", "H"};
            8'h43:   ent = '{K_LETTER, "i", "I"};
            8'h3b:   ent = '{K_LETTER, "j", "J"};
            8'h42:   ent = '{K_LETTER, "k", "K"};
            8'h4b:   ent = '{K_LETTER, "l", "L"};
            8'h3a:   ent = '{K_LETTER, "m", "M"};
            8'h31:   ent = '{K_LETTER, "n", "N"};
            8'h44:   ent = '{K_LETTER, "o", "O"};
            8'h4d:   ent = '{K_LETTER, "p", "P"};
            8'h15:   ent = '{K_LETTER, "q", "Q"};
            8'h2d:   ent = '{K_LETTER, "r", "R"};
            8'h1b:   ent = '{K_LETTER, "s", "S"};
            8'h2c:   ent = '{K_LETTER, "t", "T"};
            8'h3c:   ent = '{K_LETTER, "u", "U"};
            8'h2a:   ent = '{K_LETTER, "v", "V"};
            8'h1d:   ent = '{K_LETTER, "w", "W"};
            8'h22:   ent = '{K_LETTER, "x", "X"};
            8'h35:   ent = '{K_LETTER, "y", "Y"};
            8'h1a:   ent = '{K_LETTER, "z", "Z"};
            8'h45:   ent = '{K_SYMBOL, "0", ")"};
            8'h16:   ent = '{K_SYMBOL, "1", "!"};
            8'h1e:   ent = '{K_SYMBOL, "2", "@"};
            8'h26:   ent = '{K_SYMBOL, "3", "#"};
            8'h25:   ent = '{K_SYMBOL, "4", "$"};
            8'h2e:   ent = '{K_SYMBOL, "5", "%"};
            8'h36:   ent = '{K_SYMBOL, "6", "^"};
            8'h3d:   ent = '{K_SYMBOL, "7", "&"};
            8'h3e:   ent = '{K_SYMBOL, "8", "*"};
            8'h46:   ent = '{K_SYMBOL, "9", "("};
            8'h0e:   ent = '{K_SYMBOL, 8'h60, "~"};  // backtick
            8'h4e:   ent = '{K_SYMBOL, "-", "_"};
            8'h55:   ent = '{K_SYMBOL, "=", "+"};
            8'h54:   ent = '{K_SYMBOL, "[", "{"};
            8'h5b:   ent = '{K_SYMBOL, "]", "}"};
            8'h5d:   ent = '{K_SYMBOL, "\\", "|"};
            8'h4c:   ent = '{K_SYMBOL, ";", ":"};
            8'h52:   ent = '{K_SYMBOL, "'", "\""};
            8'h41:   ent = '{K_SYMBOL, ",", "<"};
            8'h49:   ent = '{K_SYMBOL, ".", ">"};
            8'h4a:   ent = '{K_SYMBOL, "/", "?"};
            8'h29:   ent = '{K_SYMBOL, " ", " "};  // space ignores the flags
            default: ent = '{K_NONE, 8'h00, 8'h00};
        endcase
    end

    assign upper = (ent.kind == K_LETTER) ? (ev.shift ^ ev.caps) : ev.shift;
    assign ch    = upper ? ent.hi : ent.lo;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_ascii_valid <= 1'b0;
            o_ascii       <= '0;
        end else begin
            o_ascii_valid <= ev.valid && (ent.kind != K_NONE);
            if (ev.valid && (ent.kind != K_NONE)) begin
                o_ascii <= ch;
            end
        end
    end

    a_follows_event : assert property (
        @(posedge clk) disable iff (rst) o_ascii_valid |-> $past(ev.valid)
    );

    // decoder must present clean flags with each event
    a_event_known : assert property (
        @(posedge clk) disable iff (rst)
        ev.valid |-> !$isunknown({ev.code, ev.shift, ev.caps, ev.alt_ctrl_active})
    );

endmodule

// ==== verilog/kbd_top.sv ====
`timescale 1ns/1ps

module kbd_top #(
    parameter int RELEASE_CNT_W = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_ps2_clk,
    input  logic                       i_ps2_data,
    output logic                       o_ascii_valid,
    output logic [kbd_pkg::CODE_W-1:0] o_ascii,
    output logic                       o_ctrl,
    output logic                       o_alt,
    output logic                       o_shift,
    output logic                       o_caps,
    output logic [RELEASE_CNT_W-1:0]   o_release_cnt
);
    import kbd_pkg::*;

    logic              code_valid;
    logic [CODE_W-1:0] code;

    key_event_if u_ev_if ();

    ps2_rx u_ps2_rx (
        .clk          (clk),
        .rst          (rst),
        .i_ps2_clk    (i_ps2_clk),
        .i_ps2_data   (i_ps2_data),
        .o_code_valid (code_valid),
        .o_code       (code)
    );

    key_decoder #(
        .RELEASE_CNT_W (RELEASE_CNT_W)
    ) u_key_decoder (
        .clk           (clk),
        .rst           (rst),
        .i_code_valid  (code_valid),
        .i_code        (code),
        .ev            (u_ev_if.src),
        .o_ctrl        (o_ctrl),
        .o_alt         (o_alt),
        .o_shift       (o_shift),
        .o_caps        (o_caps),
        .o_release_cnt (o_release_cnt)
    );

    ascii_map u_ascii_map (
        .clk           (clk),
        .rst           (rst),
        .ev            (u_ev_if.dst),
        .o_ascii_valid (o_ascii_valid),
        .o_ascii       (o_ascii)
    );

endmodule

// ==== verilog/key_decoder.sv ====
`timescale 1ns/1ps

module key_decoder #(
    parameter int RELEASE_CNT_W = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_code_valid,
    input  logic [kbd_pkg::CODE_W-1:0] i_code,
    key_event_if.src                   ev,
    output logic                       o_ctrl,
    output logic                       o_alt,
    output logic                       o_shift,
    output logic                       o_caps,
    output logic [RELEASE_CNT_W-1:0]   o_release_cnt
);
    import kbd_pkg::*;

    dec_state_t state_q;
    scan_code_t sc;

    assign sc = scan_code_t'(i_code);

    // flags are stable whenever a press event fires
    assign ev.shift           = o_shift;
    assign ev.caps            = o_caps;
    assign ev.alt_ctrl_active = o_ctrl | o_alt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q       <= ST_IDLE;
            ev.valid      <= 1'b0;
            o_ctrl        <= 1'b0;
            o_alt         <= 1'b0;
            o_shift       <= 1'b0;
            o_caps        <= 1'b0;
            o_release_cnt <= '0;
        end else begin
            ev.valid <= 1'b0;
            if (i_code_valid) begin
                case (state_q)
                    ST_IDLE: begin
                        case (sc)
                            SC_BREAK:              state_q <= ST_BREAK;
                            SC_EXTEND:             state_q <= ST_EXT;
                            SC_LCTRL:              o_ctrl <= 1'b1;
                            SC_LALT:               o_alt <= 1'b1;
                            SC_LSHIFT, SC_RSHIFT:  o_shift <= 1'b1;
                            SC_CAPS:               o_caps <= ~o_caps;  // repeats toggle too
                            default:               ev.valid <= 1'b1;
                        endcase
                    end
                    ST_BREAK: begin
                        o_release_cnt <= o_release_cnt + RELEASE_CNT_W'(1);
                        case (sc)
                            SC_LCTRL:              o_ctrl <= 1'b0;
                            SC_LALT:               o_alt <= 1'b0;
                            SC_LSHIFT, SC_RSHIFT:  o_shift <= 1'b0;
                            default:               ;
                        endcase
                        state_q <= ST_IDLE;
                    end
                    ST_EXT: begin
                        // extended press is swallowed
                        state_q <= (sc == SC_BREAK) ? ST_EXT_BREAK : ST_IDLE;
                    end
                    ST_EXT_BREAK: begin
                        o_release_cnt <= o_release_cnt + RELEASE_CNT_W'(1);
                        state_q       <= ST_IDLE;
                    end
                    default: state_q <= ST_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_code_valid) begin
            ev.code <= i_code;
        end
    end

    a_state_legal : assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(state_q) && (state_q inside {ST_IDLE, ST_BREAK, ST_EXT, ST_EXT_BREAK})
    );

endmodule
